// File: rtl/datapath_cfg.svh
`ifndef DATAPATH_CFG_SVH
`define DATAPATH_CFG_SVH

// bus and register width
`define DATA_WIDTH 32

// general registers R0..R15
`define REG_COUNT 16

// operation code width, room for the full instruction set
`define OP_WIDTH 5

`endif

// File: rtl/wordTypesPkg.sv
`default_nettype none

`include "datapath_cfg.svh"

package wordTypesPkg;

    typedef logic [`DATA_WIDTH-1:0] dataWord;            // one bus word
    typedef logic [2*`DATA_WIDTH-1:0] wideWord;          // mul and div results
    typedef logic [`REG_COUNT-1:0] regMask;              // one bit per general register
    typedef logic [$clog2(`REG_COUNT)-1:0] regIndex;     // register number

    // level strobes, all sampled on the rising edge of Clock
    typedef struct packed {
        logic pcOut;     // drive strobes
        logic mdrOut;
        logic zLowOut;
        logic zHighOut;
        logic hiOut;
        logic loOut;
        logic pcIn;      // load strobes
        logic marIn;
        logic mdrIn;
        logic irIn;
        logic yIn;
        logic zIn;
        logic hiIn;
        logic loIn;
        logic read;      // mdr takes memory data instead of the bus
        logic incPc;     // pc loads bus plus one
    } busStrobes;

endpackage

`default_nettype wire

// File: rtl/aluOpsPkg.sv
`default_nettype none

`include "datapath_cfg.svh"

package aluOpsPkg;
    import wordTypesPkg::*;

    typedef enum logic [`OP_WIDTH-1:0] {
        add   = 5'd0,
        sub   = 5'd1,
        andOp = 5'd2,
        orOp  = 5'd3,
        shl   = 5'd4,
        shr   = 5'd5,   // logical shift
        mul   = 5'd6,
        div   = 5'd7,
        inc   = 5'd8
    } aluOp;

    // Z register layout, high word on top
    typedef struct packed {
        dataWord high;   // product high or remainder
        dataWord low;    // product low, quotient or plain result
    } aluResult;

endpackage

`default_nettype wire

// File: rtl/memoryPort.sv
`timescale 1ns/1ps
`default_nettype none

module memoryPort
    import wordTypesPkg::*;
(
    input  logic      Clock,
    input  logic      rstN,
    input  busStrobes strobes,
    input  dataWord   bus,
    input  dataWord   memDataIn,
    output dataWord   mdrValue,
    output dataWord   marOut,
    output dataWord   irOut
);

    dataWord mdrNext;

    // read selects memory over the bus
    assign mdrNext = strobes.read ? memDataIn : bus;

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            mdrValue <= '0;
        end else if (strobes.mdrIn) begin
            mdrValue <= mdrNext;
        end
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            marOut <= '0;
        end else if (strobes.marIn) begin
            marOut <= bus;              // address goes straight out to memory
        end
    end

    // instruction word is only held, decoding is outside this datapath
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            irOut <= '0;
        end else if (strobes.irIn) begin
            irOut <= bus;
        end
    end

endmodule

`default_nettype wire

// File: rtl/registerBank.sv
`timescale 1ns/1ps
`default_nettype none

`include "datapath_cfg.svh"

module registerBank
    import wordTypesPkg::*;
(
    input  logic    Clock,
    input  logic    rstN,
    input  regMask  regIn,
    input  regMask  regOut,
    input  dataWord bus,
    output dataWord regDrive
);

    dataWord regs [`REG_COUNT];

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                if (regIn[i]) begin
                    regs[i] <= bus;     // several may load the same word
                end
            end
        end
    end

    // gated OR of all driving registers, merged again in busDriver
    always_comb begin
        regDrive = '0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            if (regOut[i]) begin
                regDrive = regDrive | regs[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/arithUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "datapath_cfg.svh"

module arithUnit
    import wordTypesPkg::*;
    import aluOpsPkg::*;
(
    input  logic      Clock,
    input  logic      rstN,
    input  busStrobes strobes,
    input  aluOp      op,
    input  dataWord   bus,
    output aluResult  zValue
);

    dataWord  yValue;
    aluResult result;
    wideWord  product;
    dataWord  quotient;
    dataWord  remainder;
    logic     divByZero;
    logic [$clog2(`DATA_WIDTH)-1:0] shiftAmt;

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            yValue <= '0;
        end else if (strobes.yIn) begin
            yValue <= bus;              // first operand
        end
    end

    assign shiftAmt  = bus[$clog2(`DATA_WIDTH)-1:0];
    assign divByZero = (bus == '0);

    // signed product, sign extended to the full double word
    assign product = $signed(yValue) * $signed(bus);

    // Y over the bus, both signed
    assign quotient  = $signed(yValue) / $signed(bus);
    assign remainder = $signed(yValue) % $signed(bus);

    always_comb begin
        result = '0;
        case (op)
            add:   result.low = yValue + bus;
            sub:   result.low = yValue - bus;
            andOp: result.low = yValue & bus;
            orOp:  result.low = yValue | bus;
            shl:   result.low = yValue << shiftAmt;
            shr:   result.low = yValue >> shiftAmt;
            mul:   result = product;
            div: begin
                if (divByZero) begin
                    result.low  = '1;   // all ones, remainder keeps the dividend
                    result.high = yValue;
                end else begin
                    result.low  = quotient;
                    result.high = remainder;
                end
            end
            inc:   result.low = bus + 1'b1;
            default: result = '0;
        endcase
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            zValue <= '0;
        end else if (strobes.zIn) begin
            zValue <= result;           // low and high together
        end
    end

endmodule

`default_nettype wire

// File: rtl/busDriver.sv
`timescale 1ns/1ps
`default_nettype none

`include "datapath_cfg.svh"

module busDriver
    import wordTypesPkg::*;
    import aluOpsPkg::*;
(
    input  logic      Clock,
    input  logic      rstN,
    input  busStrobes strobes,
    input  dataWord   mdrValue,
    input  dataWord   regDrive,
    input  aluResult  zValue,
    output dataWord   bus
);

    dataWord pcValue;
    dataWord hiValue;
    dataWord loValue;
    dataWord pcNext;

    // increment stays local to the pc, no trip through Z
    assign pcNext = strobes.incPc ? bus + 1'b1 : bus;

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            pcValue <= '0;
        end else if (strobes.pcIn) begin
            pcValue <= pcNext;
        end
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            hiValue <= '0;
            loValue <= '0;
        end else begin
            if (strobes.hiIn) begin
                hiValue <= bus;
            end
            if (strobes.loIn) begin
                loValue <= bus;
            end
        end
    end

    // at most one source is expected; overlaps simply OR together
    assign bus = ({`DATA_WIDTH{strobes.pcOut}}    & pcValue)
               | ({`DATA_WIDTH{strobes.mdrOut}}   & mdrValue)
               | ({`DATA_WIDTH{strobes.zLowOut}}  & zValue.low)
               | ({`DATA_WIDTH{strobes.zHighOut}} & zValue.high)
               | ({`DATA_WIDTH{strobes.hiOut}}    & hiValue)
               | ({`DATA_WIDTH{strobes.loOut}}    & loValue)
               | regDrive;                  // already gated per register

endmodule

`default_nettype wire

// File: rtl/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath
    import wordTypesPkg::*;
    import aluOpsPkg::*;
(
    input  logic      Clock,
    input  logic      rstN,
    input  busStrobes strobes,
    input  regMask    regIn,
    input  regMask    regOut,
    input  aluOp      op,
    input  dataWord   memDataIn,
    output dataWord   bus,
    output dataWord   marOut,
    output dataWord   irOut
);

    dataWord  mdrValue;
    dataWord  regDrive;
    aluResult zValue;

    memoryPort uMemoryPort (
        .Clock(Clock), .rstN(rstN), .strobes(strobes), .bus(bus),
        .memDataIn(memDataIn), .mdrValue(mdrValue), .marOut(marOut), .irOut(irOut)
    );

    registerBank uRegisterBank (
        .Clock(Clock), .rstN(rstN), .regIn(regIn), .regOut(regOut),
        .bus(bus), .regDrive(regDrive)
    );

    arithUnit uArithUnit (
        .Clock(Clock), .rstN(rstN), .strobes(strobes), .op(op),
        .bus(bus), .zValue(zValue)
    );

    // single bus source, fed back to every block above
    busDriver uBusDriver (
        .Clock(Clock), .rstN(rstN), .strobes(strobes), .mdrValue(mdrValue),
        .regDrive(regDrive), .zValue(zValue), .bus(bus)
    );

endmodule

`default_nettype wire

// File: tb/datapath_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "datapath_cfg.svh"

module datapath_tb
    import wordTypesPkg::*;
    import aluOpsPkg::*;
();

    localparam int MAX_CYCLES = 600;                 // tests need roughly 300 cycles
    localparam int LOAD_REGS [3] = '{2, 4, 5};
    localparam aluOp PLAIN_OPS [7] = '{add, sub, andOp, orOp, shl, shr, inc};

    logic      Clock;
    logic      rstN;
    busStrobes strobes;
    regMask    regIn;
    regMask    regOut;
    aluOp      op;
    dataWord   memDataIn;
    dataWord   bus;
    dataWord   marOut;
    dataWord   irOut;

    int cycleCount = 0;
    int checkCount = 0;
    int errorCount = 0;
    logic [31:0] lfsrState;

    datapath DUT (
        .Clock(Clock), .rstN(rstN), .strobes(strobes), .regIn(regIn), .regOut(regOut),
        .op(op), .memDataIn(memDataIn), .bus(bus), .marOut(marOut), .irOut(irOut)
    );

    initial begin
        Clock = 1'b0;
        forever #10 Clock = ~Clock;
    end

    always @(posedge Clock) begin
        cycleCount++;
        if (cycleCount >= MAX_CYCLES) begin
            $display("timeout: the run went past %0d clock cycles without finishing", MAX_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic dataWord nextRandom();
        dataWord word;
        word = '0;
        for (int i = 0; i < `DATA_WIDTH; i++) begin
            lfsrState = lfsrStep(lfsrState);                // one step per bit taken
            word = {word[`DATA_WIDTH-2:0], lfsrState[0]};
        end
        return word;
    endfunction

    // expected Z contents with the signed math done in 64 bits
    function automatic aluResult expectResult(input aluOp code, input dataWord y,
                                              input dataWord b);
        aluResult r;
        longint sy;
        longint sb;
        sy = longint'($signed(y));
        sb = longint'($signed(b));
        r = '0;
        case (code)
            add:   r.low = y + b;
            sub:   r.low = y + ~b + 32'd1;
            andOp: r.low = y & b;
            orOp:  r.low = y | b;
            shl:   r.low = y << b[4:0];
            shr:   r.low = y >> b[4:0];
            mul:   r = aluResult'(sy * sb);
            div: begin
                if (b == '0) begin
                    r.low  = '1;
                    r.high = y;
                end else begin
                    r.low  = dataWord'(sy / sb);
                    r.high = dataWord'(sy % sb);    // sign follows the dividend
                end
            end
            inc:   r.low = b + 32'd1;
            default: r = '0;
        endcase
        return r;
    endfunction

    task automatic clearInputs();
        strobes = '0;
        regIn = '0;
        regOut = '0;
        op = add;
        memDataIn = '0;
    endtask

    // hold the driven inputs through one rising edge and drop them after
    task automatic endCycle();
        @(negedge Clock);
        clearInputs();
    endtask

    task automatic checkWord(input string name, input dataWord expected, input dataWord actual);
        checkCount++;
        assert (actual === expected)
        else begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkBus(input string name, input dataWord expected);
        #5;                                             // bus has settled by mid low phase
        checkWord(name, expected, bus);
        endCycle();
    endtask

    task automatic memLoad(input dataWord word, input int idx);
        strobes.read = 1'b1;
        strobes.mdrIn = 1'b1;
        memDataIn = word;
        endCycle();
        strobes.mdrOut = 1'b1;
        regIn[idx] = 1'b1;
        endCycle();
    endtask

    task automatic runOp(input aluOp code, input int srcA, input int srcB);
        regOut[srcA] = 1'b1;
        strobes.yIn = 1'b1;
        endCycle();
        regOut[srcB] = 1'b1;
        strobes.zIn = 1'b1;
        op = code;
        endCycle();
    endtask

    task automatic plainCase(input aluOp code, input dataWord a, input dataWord b);
        aluResult expected;
        expected = expectResult(code, a, b);
        memLoad(a, 1);
        memLoad(b, 3);
        runOp(code, 1, 3);
        strobes.zLowOut = 1'b1;
        checkBus({"alu ", code.name()}, expected.low);
    endtask

    // result goes Z low to LO and Z high to HI before it is read back
    task automatic wideCase(input string name, input aluOp code,
                            input dataWord a, input dataWord b);
        aluResult expected;
        expected = expectResult(code, a, b);
        memLoad(a, 1);
        memLoad(b, 3);
        runOp(code, 1, 3);
        strobes.zLowOut = 1'b1;
        strobes.loIn = 1'b1;
        endCycle();
        strobes.zHighOut = 1'b1;
        strobes.hiIn = 1'b1;
        endCycle();
        strobes.loOut = 1'b1;
        checkBus({name, " lo"}, expected.low);
        strobes.hiOut = 1'b1;
        checkBus({name, " hi"}, expected.high);
    endtask

    task automatic reportTest(input string name, input int startErrors);
        $display("test %s finished, %0d errors", name, errorCount - startErrors);
    endtask

    initial begin
        int startErrors;
        dataWord words [3];
        dataWord oldPc;
        dataWord instr;
        lfsrState = 32'h6e4034b8;
        clearInputs();
        rstN = 1'b0;
        repeat (2) @(negedge Clock);
        rstN = 1'b1;

        startErrors = errorCount;
        #5;
        checkWord("reset bus", '0, bus);
        checkWord("reset mar", '0, marOut);
        checkWord("reset ir", '0, irOut);
        @(negedge Clock);
        reportTest("reset", startErrors);

        startErrors = errorCount;
        for (int i = 0; i < 3; i++) begin
            words[i] = nextRandom();
            memLoad(words[i], LOAD_REGS[i]);
        end
        for (int i = 0; i < 3; i++) begin
            regOut[LOAD_REGS[i]] = 1'b1;
            checkBus($sformatf("registers R%0d", LOAD_REGS[i]), words[i]);
        end
        words[0] = nextRandom();
        memLoad(words[0], 2);                          // overwrite R2
        regOut[2] = 1'b1;
        checkBus("registers R2 reload", words[0]);
        regOut[4] = 1'b1;
        checkBus("registers R4 kept", words[1]);
        reportTest("registers", startErrors);

        startErrors = errorCount;
        oldPc = nextRandom();
        instr = nextRandom();
        strobes.read = 1'b1;
        strobes.mdrIn = 1'b1;
        memDataIn = oldPc;
        endCycle();
        strobes.mdrOut = 1'b1;
        strobes.pcIn = 1'b1;
        endCycle();
        strobes.pcOut = 1'b1;
        strobes.marIn = 1'b1;
        strobes.incPc = 1'b1;
        strobes.pcIn = 1'b1;
        endCycle();
        strobes.read = 1'b1;
        strobes.mdrIn = 1'b1;
        memDataIn = instr;
        endCycle();
        strobes.mdrOut = 1'b1;
        strobes.irIn = 1'b1;
        endCycle();
        strobes.pcOut = 1'b1;
        #5;
        checkWord("fetch mar", oldPc, marOut);
        checkWord("fetch ir", instr, irOut);
        checkWord("fetch pc", oldPc + 32'd1, bus);
        endCycle();
        reportTest("fetch", startErrors);

        startErrors = errorCount;
        for (int k = 0; k < 7; k++) begin
            repeat (4) plainCase(PLAIN_OPS[k], nextRandom(), nextRandom());
        end
        reportTest("alu", startErrors);

        startErrors = errorCount;
        repeat (4) wideCase("mul", mul, nextRandom(), nextRandom());
        repeat (3) wideCase("div", div, nextRandom(), nextRandom());
        wideCase("div by zero", div, nextRandom(), '0);
        reportTest("muldiv", startErrors);

        $display("checks %0d, errors %0d, cycles %0d", checkCount, errorCount, cycleCount);
        if (errorCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+rtl
rtl/wordTypesPkg.sv
rtl/aluOpsPkg.sv
rtl/memoryPort.sv
rtl/registerBank.sv
rtl/arithUnit.sv
rtl/busDriver.sv
rtl/datapath.sv
tb/datapath_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module datapath_tb -o simv
./obj_dir/simv | tee sim.log

if grep -q "^STATUS: PASS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
